// File: verilog/fight_pkg.sv
package fight_pkg;

  typedef enum logic [3:0] {
    IDLE       = 4'd0,
    MOVE_FWD   = 4'd1,
    MOVE_BACK  = 4'd2,
    B_START    = 4'd3,
    B_ACTIVE   = 4'd4,
    B_RECOVER  = 4'd5,
    D_START    = 4'd6,
    D_ACTIVE   = 4'd7,
    D_RECOVER  = 4'd8,
    HIT_STUN   = 4'd9,
    BLOCK_STUN = 4'd10
  } fighter_state_e;

  typedef enum logic [1:0] {NONE = 2'd0, BASIC = 2'd1, DIRECTIONAL = 2'd2} hit_kind_e;
  typedef enum logic [1:0] {WAIT = 2'd0, FIGHT = 2'd1, OVER = 2'd2} match_state_e;
  typedef enum logic [1:0] {NOBODY = 2'd0, LEFT = 2'd1, RIGHT = 2'd2} winner_e;

  localparam int POS_W    = 10;
  localparam int HEALTH_W = 3;
  localparam int PHASE_W  = 5;

  // Phase lengths in frames
  localparam logic [PHASE_W-1:0] B_START_LEN      = 5'd5;
  localparam logic [PHASE_W-1:0] B_ACTIVE_LEN     = 5'd2;
  localparam logic [PHASE_W-1:0] B_RECOVER_LEN    = 5'd16;
  localparam logic [PHASE_W-1:0] D_START_LEN      = 5'd4;
  localparam logic [PHASE_W-1:0] D_ACTIVE_LEN     = 5'd3;
  localparam logic [PHASE_W-1:0] D_RECOVER_LEN    = 5'd15;
  localparam logic [PHASE_W-1:0] HIT_STUN_BASIC   = 5'd16;
  localparam logic [PHASE_W-1:0] HIT_STUN_DIR     = 5'd16;
  localparam logic [PHASE_W-1:0] BLOCK_STUN_BASIC = 5'd14;
  localparam logic [PHASE_W-1:0] BLOCK_STUN_DIR   = 5'd14;

  // Pixels per frame, walls and spacing
  localparam logic [POS_W-1:0] SPEED_FWD   = 10'd3;
  localparam logic [POS_W-1:0] SPEED_BACK  = 10'd2;
  localparam logic [POS_W-1:0] POS_MIN     = 10'd10;
  localparam logic [POS_W-1:0] POS_MAX     = 10'd517;
  localparam logic [POS_W-1:0] MIN_GAP     = 10'd30;
  localparam logic [POS_W-1:0] START_LEFT  = 10'd100;
  localparam logic [POS_W-1:0] START_RIGHT = 10'd427;

  // Box offsets from posx, left-facing; right side mirrors against MIRROR_W
  localparam logic [POS_W-1:0] BASIC_X1_OFF = 10'd35;
  localparam logic [POS_W-1:0] BASIC_X2_OFF = 10'd113;
  localparam logic [POS_W-1:0] DIR_X1_OFF   = 10'd62;
  localparam logic [POS_W-1:0] DIR_X2_OFF   = 10'd95;
  localparam logic [POS_W-1:0] HURT_X1_OFF  = 10'd28;
  localparam logic [POS_W-1:0] HURT_X2_OFF  = 10'd81;
  localparam logic [POS_W-1:0] MIRROR_W     = 10'd113;

endpackage

// File: verilog/fighter_if.sv
`timescale 1ns/1ns

// One fighter's view as seen by the hit judge
interface fighter_if;

  fight_pkg::fighter_state_e    state;
  logic [fight_pkg::POS_W-1:0]  posx;
  logic                         atk_on;
  fight_pkg::hit_kind_e         atk_kind;
  logic [fight_pkg::POS_W-1:0]  atk_x1;
  logic [fight_pkg::POS_W-1:0]  atk_x2;
  logic [fight_pkg::POS_W-1:0]  hurt_x1;
  logic [fight_pkg::POS_W-1:0]  hurt_x2;

  modport fighter (
    output state, posx,
    output atk_on, atk_kind,
    output atk_x1, atk_x2,
    output hurt_x1, hurt_x2
  );

  modport judge (
    input state, posx,
    input atk_on, atk_kind,
    input atk_x1, atk_x2,
    input hurt_x1, hurt_x2
  );

endinterface

// File: verilog/fighter.sv
`timescale 1ns/1ns

module fighter #(
  parameter bit SIDE = 1'b0
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        frame_tick,
  input  logic                        fighting,
  input  logic                        round_start,
  input  logic                        left,
  input  logic                        right,
  input  logic                        attack,
  input  fight_pkg::hit_kind_e        hit,
  input  logic [fight_pkg::POS_W-1:0] other_posx,
  fighter_if.fighter                  box
);

  localparam logic [fight_pkg::POS_W-1:0] START_POS =
    SIDE ? fight_pkg::START_RIGHT : fight_pkg::START_LEFT;

  fight_pkg::fighter_state_e      state;
  fight_pkg::fighter_state_e      next_state;
  fight_pkg::fighter_state_e      key_state;
  logic [fight_pkg::POS_W-1:0]    posx;
  logic [fight_pkg::PHASE_W-1:0]  phase_cnt;
  logic [fight_pkg::PHASE_W-1:0]  phase_len;
  logic [fight_pkg::PHASE_W-1:0]  stun_len;
  logic [fight_pkg::PHASE_W-1:0]  next_stun_len;
  logic                           phase_done;
  logic                           fwd_ok;
  logic                           back_ok;
  logic [fight_pkg::POS_W-1:0]    fwd_pos;
  logic [fight_pkg::POS_W-1:0]    back_pos;
  logic [fight_pkg::POS_W-1:0]    atk_lo;
  logic [fight_pkg::POS_W-1:0]    atk_hi;

  // Length of the current phase; free states count as one frame
  always_comb begin
    case (state)
      fight_pkg::B_START:    phase_len = fight_pkg::B_START_LEN;
      fight_pkg::B_ACTIVE:   phase_len = fight_pkg::B_ACTIVE_LEN;
      fight_pkg::B_RECOVER:  phase_len = fight_pkg::B_RECOVER_LEN;
      fight_pkg::D_START:    phase_len = fight_pkg::D_START_LEN;
      fight_pkg::D_ACTIVE:   phase_len = fight_pkg::D_ACTIVE_LEN;
      fight_pkg::D_RECOVER:  phase_len = fight_pkg::D_RECOVER_LEN;
      fight_pkg::HIT_STUN,
      fight_pkg::BLOCK_STUN: phase_len = stun_len;
      default:               phase_len = 5'd1;
    endcase
  end

  // Counter holds ticks spent in the phase minus one
  assign phase_done = (phase_cnt >= phase_len - 5'd1);

  // Direction keys, forward depends on which side we face from
  always_comb begin
    if (left && right) begin
      key_state = fight_pkg::MOVE_BACK;
    end else if (left) begin
      key_state = SIDE ? fight_pkg::MOVE_FWD : fight_pkg::MOVE_BACK;
    end else if (right) begin
      key_state = SIDE ? fight_pkg::MOVE_BACK : fight_pkg::MOVE_FWD;
    end else begin
      key_state = fight_pkg::IDLE;
    end
  end

  always_comb begin
    next_stun_len = stun_len;
    if (hit != fight_pkg::NONE) begin
      if (state == fight_pkg::MOVE_BACK) begin
        next_state    = fight_pkg::BLOCK_STUN;
        next_stun_len = (hit == fight_pkg::DIRECTIONAL) ?
                        fight_pkg::BLOCK_STUN_DIR : fight_pkg::BLOCK_STUN_BASIC;
      end else begin
        next_state    = fight_pkg::HIT_STUN;
        next_stun_len = (hit == fight_pkg::DIRECTIONAL) ?
                        fight_pkg::HIT_STUN_DIR : fight_pkg::HIT_STUN_BASIC;
      end
    end else if (!phase_done) begin
      next_state = state;
    end else if (state == fight_pkg::B_START) begin
      next_state = fight_pkg::B_ACTIVE;
    end else if (state == fight_pkg::B_ACTIVE) begin
      next_state = fight_pkg::B_RECOVER;
    end else if (state == fight_pkg::D_START) begin
      next_state = fight_pkg::D_ACTIVE;
    end else if (state == fight_pkg::D_ACTIVE) begin
      next_state = fight_pkg::D_RECOVER;
    end else if (attack) begin
      // Attacking out of a walk gives the directional move
      if (state == fight_pkg::MOVE_FWD || state == fight_pkg::MOVE_BACK) begin
        next_state = fight_pkg::D_START;
      end else begin
        next_state = fight_pkg::B_START;
      end
    end else begin
      next_state = key_state;
    end
  end

  // Step only when the result stays between the walls
  assign fwd_pos  = SIDE ? posx - fight_pkg::SPEED_FWD : posx + fight_pkg::SPEED_FWD;
  assign back_pos = SIDE ? posx + fight_pkg::SPEED_BACK : posx - fight_pkg::SPEED_BACK;

  assign fwd_ok = SIDE ?
    (posx >= fight_pkg::POS_MIN + fight_pkg::SPEED_FWD) &&
    (other_posx + fight_pkg::MIN_GAP < posx) :
    (posx + fight_pkg::SPEED_FWD <= fight_pkg::POS_MAX) &&
    (posx + fight_pkg::MIN_GAP < other_posx);

  assign back_ok = SIDE ?
    (posx + fight_pkg::SPEED_BACK <= fight_pkg::POS_MAX) :
    (posx >= fight_pkg::POS_MIN + fight_pkg::SPEED_BACK);

  always_ff @(posedge clk) begin
    if (rst || round_start) begin
      state     <= fight_pkg::IDLE;
      posx      <= START_POS;
      phase_cnt <= '0;
      stun_len  <= fight_pkg::HIT_STUN_BASIC;
    end else if (frame_tick && fighting) begin
      state    <= next_state;
      stun_len <= next_stun_len;
      if (next_state != state) begin
        phase_cnt <= '0;
      end else if (phase_cnt != '1) begin
        phase_cnt <= phase_cnt + 5'd1;
      end
      if (state == fight_pkg::MOVE_FWD && fwd_ok) begin
        posx <= fwd_pos;
      end else if (state == fight_pkg::MOVE_BACK && back_ok) begin
        posx <= back_pos;
      end
    end
  end

  // Boxes
  always_comb begin
    if (box.atk_kind == fight_pkg::DIRECTIONAL) begin
      atk_lo = fight_pkg::DIR_X1_OFF;
      atk_hi = fight_pkg::DIR_X2_OFF;
    end else begin
      atk_lo = fight_pkg::BASIC_X1_OFF;
      atk_hi = fight_pkg::BASIC_X2_OFF;
    end
  end

  assign box.state    = state;
  assign box.posx     = posx;
  assign box.atk_on   = (state == fight_pkg::B_ACTIVE) || (state == fight_pkg::D_ACTIVE);
  assign box.atk_kind = (state == fight_pkg::B_ACTIVE) ? fight_pkg::BASIC :
                        (state == fight_pkg::D_ACTIVE) ? fight_pkg::DIRECTIONAL :
                        fight_pkg::NONE;

  assign box.atk_x1  = SIDE ? posx + fight_pkg::MIRROR_W - atk_hi : posx + atk_lo;
  assign box.atk_x2  = SIDE ? posx + fight_pkg::MIRROR_W - atk_lo : posx + atk_hi;
  assign box.hurt_x1 = SIDE ? posx + fight_pkg::MIRROR_W - fight_pkg::HURT_X2_OFF :
                              posx + fight_pkg::HURT_X1_OFF;
  assign box.hurt_x2 = SIDE ? posx + fight_pkg::MIRROR_W - fight_pkg::HURT_X1_OFF :
                              posx + fight_pkg::HURT_X2_OFF;

endmodule

// File: verilog/hit_judge.sv
`timescale 1ns/1ns

module hit_judge (
  fighter_if.judge             left_box,
  fighter_if.judge             right_box,
  output fight_pkg::hit_kind_e hit_left,
  output fight_pkg::hit_kind_e hit_right,
  output logic                 landed_left,
  output logic                 landed_right
);

  logic left_overlap;
  logic right_overlap;
  logic left_stunned;
  logic right_stunned;

  // Inclusive span overlap
  function automatic logic spans_meet(
    input logic [fight_pkg::POS_W-1:0] a1,
    input logic [fight_pkg::POS_W-1:0] a2,
    input logic [fight_pkg::POS_W-1:0] b1,
    input logic [fight_pkg::POS_W-1:0] b2
  );
    return (a1 <= b2) && (b1 <= a2);
  endfunction

  function automatic logic in_stun(input fight_pkg::fighter_state_e st);
    return (st == fight_pkg::HIT_STUN) || (st == fight_pkg::BLOCK_STUN);
  endfunction

  // Attacker's box against the defender's hurt box
  assign left_overlap  = spans_meet(right_box.atk_x1, right_box.atk_x2,
                                    left_box.hurt_x1, left_box.hurt_x2);
  assign right_overlap = spans_meet(left_box.atk_x1, left_box.atk_x2,
                                    right_box.hurt_x1, right_box.hurt_x2);

  assign left_stunned  = in_stun(left_box.state);
  assign right_stunned = in_stun(right_box.state);

  // Defender already reeling takes no further hit
  always_comb begin
    if (right_box.atk_on && left_overlap && !left_stunned) begin
      hit_left = right_box.atk_kind;
    end else begin
      hit_left = fight_pkg::NONE;
    end
  end

  always_comb begin
    if (left_box.atk_on && right_overlap && !right_stunned) begin
      hit_right = left_box.atk_kind;
    end else begin
      hit_right = fight_pkg::NONE;
    end
  end

  // Walking back blocks
  assign landed_left  = (hit_left != fight_pkg::NONE) &&
                        (left_box.state != fight_pkg::MOVE_BACK);
  assign landed_right = (hit_right != fight_pkg::NONE) &&
                        (right_box.state != fight_pkg::MOVE_BACK);

endmodule

// File: verilog/match_ctrl.sv
`timescale 1ns/1ns

module match_ctrl #(
  parameter logic [fight_pkg::HEALTH_W-1:0] START_HEALTH = 3'd5
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           frame_tick,
  input  logic                           start,
  input  logic                           landed_left,
  input  logic                           landed_right,
  output logic                           round_start,
  output logic                           fighting,
  output fight_pkg::match_state_e        match_state,
  output logic [fight_pkg::HEALTH_W-1:0] health_left,
  output logic [fight_pkg::HEALTH_W-1:0] health_right,
  output fight_pkg::winner_e             winner
);

  logic [fight_pkg::HEALTH_W-1:0] next_left;
  logic [fight_pkg::HEALTH_W-1:0] next_right;

  assign fighting    = (match_state == fight_pkg::FIGHT);
  assign round_start = start && (match_state != fight_pkg::FIGHT);

  // Floor at zero
  assign next_left  = (landed_left && health_left != '0) ? health_left - 3'd1 : health_left;
  assign next_right = (landed_right && health_right != '0) ? health_right - 3'd1 : health_right;

  always_ff @(posedge clk) begin
    if (rst) begin
      match_state  <= fight_pkg::WAIT;
      health_left  <= START_HEALTH;
      health_right <= START_HEALTH;
      winner       <= fight_pkg::NOBODY;
    end else if (round_start) begin
      match_state  <= fight_pkg::FIGHT;
      health_left  <= START_HEALTH;
      health_right <= START_HEALTH;
      winner       <= fight_pkg::NOBODY;
    end else if (fighting && frame_tick) begin
      health_left  <= next_left;
      health_right <= next_right;
      if (next_left == '0 || next_right == '0) begin
        match_state <= fight_pkg::OVER;
        if (next_left == '0 && next_right == '0) begin
          winner <= fight_pkg::NOBODY;
        end else if (next_left == '0) begin
          winner <= fight_pkg::RIGHT;
        end else begin
          winner <= fight_pkg::LEFT;
        end
      end
    end
  end

endmodule

// File: verilog/fight_core.sv
`timescale 1ns/1ns

module fight_core #(
  parameter logic [fight_pkg::HEALTH_W-1:0] START_HEALTH = 3'd5
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           frame_tick,
  input  logic                           start,
  input  logic                           p1_left,
  input  logic                           p1_right,
  input  logic                           p1_attack,
  input  logic                           p2_left,
  input  logic                           p2_right,
  input  logic                           p2_attack,
  output logic [fight_pkg::POS_W-1:0]    p1_posx,
  output logic [fight_pkg::POS_W-1:0]    p2_posx,
  output logic [3:0]                     p1_state,
  output logic [3:0]                     p2_state,
  output logic [fight_pkg::HEALTH_W-1:0] p1_health,
  output logic [fight_pkg::HEALTH_W-1:0] p2_health,
  output fight_pkg::match_state_e        match_state,
  output fight_pkg::winner_e             winner
);

  fight_pkg::hit_kind_e hit_left;
  fight_pkg::hit_kind_e hit_right;
  logic                 landed_left;
  logic                 landed_right;
  logic                 round_start;
  logic                 fighting;

  fighter_if left_if ();
  fighter_if right_if ();

  // Player one stands on the left
  fighter #(.SIDE(1'b0)) i_fighter_left (
    .clk(clk), .rst(rst), .frame_tick(frame_tick),
    .fighting(fighting), .round_start(round_start),
    .left(p1_left), .right(p1_right), .attack(p1_attack),
    .hit(hit_left), .other_posx(right_if.posx),
    .box(left_if.fighter)
  );

  fighter #(.SIDE(1'b1)) i_fighter_right (
    .clk(clk), .rst(rst), .frame_tick(frame_tick),
    .fighting(fighting), .round_start(round_start),
    .left(p2_left), .right(p2_right), .attack(p2_attack),
    .hit(hit_right), .other_posx(left_if.posx),
    .box(right_if.fighter)
  );

  hit_judge i_hit_judge (
    .left_box(left_if.judge), .right_box(right_if.judge),
    .hit_left(hit_left), .hit_right(hit_right),
    .landed_left(landed_left), .landed_right(landed_right)
  );

  match_ctrl #(.START_HEALTH(START_HEALTH)) i_match_ctrl (
    .clk(clk), .rst(rst), .frame_tick(frame_tick), .start(start),
    .landed_left(landed_left), .landed_right(landed_right),
    .round_start(round_start), .fighting(fighting), .match_state(match_state),
    .health_left(p1_health), .health_right(p2_health), .winner(winner)
  );

  assign p1_posx  = left_if.posx;
  assign p2_posx  = right_if.posx;
  assign p1_state = left_if.state;
  assign p2_state = right_if.state;

endmodule

// File: verif/fight_core_chk.sv
`timescale 1ns/1ns

module fight_core_chk (
  input logic                           clk,
  input logic                           rst,
  input fight_pkg::match_state_e        match_state,
  input fight_pkg::winner_e             winner,
  input logic [fight_pkg::POS_W-1:0]    p1_posx,
  input logic [fight_pkg::POS_W-1:0]    p2_posx,
  input logic [fight_pkg::HEALTH_W-1:0] p1_health,
  input logic [fight_pkg::HEALTH_W-1:0] p2_health
);

  // Health only falls while a round runs
  assert property (@(posedge clk) disable iff (rst)
    (match_state == fight_pkg::FIGHT && $past(match_state) == fight_pkg::FIGHT) |->
    (p1_health <= $past(p1_health) && p2_health <= $past(p2_health)))
    else $error("health rose during a round");

  assert property (@(posedge clk) disable iff (rst)
    p1_posx >= fight_pkg::POS_MIN && p1_posx <= fight_pkg::POS_MAX &&
    p2_posx >= fight_pkg::POS_MIN && p2_posx <= fight_pkg::POS_MAX)
    else $error("position outside the walls");

  assert property (@(posedge clk) disable iff (rst)
    match_state != fight_pkg::OVER |-> winner == fight_pkg::NOBODY)
    else $error("winner named before the round is over");

  assert property (@(posedge clk) disable iff (rst) p1_posx < p2_posx)
    else $error("fighters crossed");

endmodule

bind fight_core fight_core_chk i_chk (.*);

// File: verif/fight_core_tb.sv
`timescale 1ns/1ns

module fight_core_tb;

  logic clk;
  logic rst;
  logic frame_tick;
  logic start;
  logic p1_left, p1_right, p1_attack;
  logic p2_left, p2_right, p2_attack;
  logic [9:0] p1_posx, p2_posx;
  logic [3:0] p1_state, p2_state;
  logic [2:0] p1_health, p2_health;
  logic [1:0] match_state, winner;

  int m_state[2], m_pos[2], m_age[2], m_stun[2], m_health[2];
  int m_match, m_winner;
  int errors, checks, cycles;
  bit pending;

  fight_core #(.START_HEALTH(3'd2)) i_fight_core (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  function automatic int phase_len(input int st, input int stun);
    case (st)
      3: return 5;
      4: return 2;
      5: return 16;
      6: return 4;
      7: return 3;
      8: return 15;
      9, 10: return stun;
      default: return 1;
    endcase
  endfunction

  function void reset_model(input int match);
    m_state = '{0, 0};
    m_pos = '{100, 427};
    m_age = '{0, 0};
    m_stun = '{16, 16};
    m_health = '{2, 2};
    m_match = match;
    m_winner = 0;
  endfunction

  // One frame of both fighters, the judge and the match from the game rules
  function void step_model(input bit [1:0] kl, input bit [1:0] kr, input bit [1:0] ka);
    int hk[2], ns[2], np[2], a, lo, hi, ax1, ax2, hx1, hx2, other;
    bit landed[2];
    if (m_match != 1) return;
    for (int d = 0; d < 2; d++) begin
      a = 1 - d;
      lo = (m_state[a] == 7) ? 62 : 35;
      hi = (m_state[a] == 7) ? 95 : 113;
      ax1 = (a == 0) ? m_pos[a] + lo : m_pos[a] + 113 - hi;
      ax2 = (a == 0) ? m_pos[a] + hi : m_pos[a] + 113 - lo;
      hx1 = (d == 0) ? m_pos[d] + 28 : m_pos[d] + 32;
      hx2 = (d == 0) ? m_pos[d] + 81 : m_pos[d] + 85;
      hk[d] = 0;
      if ((m_state[a] == 4 || m_state[a] == 7) && ax1 <= hx2 && hx1 <= ax2 &&
          m_state[d] != 9 && m_state[d] != 10)
        hk[d] = (m_state[a] == 4) ? 1 : 2;
      landed[d] = (hk[d] != 0) && (m_state[d] != 2);
    end
    for (int i = 0; i < 2; i++) begin
      other = m_pos[1 - i];
      if (hk[i] != 0) begin
        ns[i] = (m_state[i] == 2) ? 10 : 9;
        m_stun[i] = (m_state[i] == 2) ? 14 : 16;
      end else if (m_age[i] + 1 < phase_len(m_state[i], m_stun[i]))
        ns[i] = m_state[i];
      else if (m_state[i] == 3 || m_state[i] == 4 || m_state[i] == 6 || m_state[i] == 7)
        ns[i] = m_state[i] + 1;
      else if (ka[i])
        ns[i] = (m_state[i] == 1 || m_state[i] == 2) ? 6 : 3;
      else if (kl[i] && kr[i])
        ns[i] = 2;
      else if (kl[i])
        ns[i] = (i == 0) ? 2 : 1;
      else if (kr[i])
        ns[i] = (i == 0) ? 1 : 2;
      else
        ns[i] = 0;
      np[i] = m_pos[i];
      if (m_state[i] == 1) begin
        if (i == 0 && m_pos[i] + 3 <= 517 && m_pos[i] + 30 < other) np[i] = m_pos[i] + 3;
        if (i == 1 && m_pos[i] >= 13 && other + 30 < m_pos[i]) np[i] = m_pos[i] - 3;
      end else if (m_state[i] == 2) begin
        if (i == 0 && m_pos[i] >= 12) np[i] = m_pos[i] - 2;
        if (i == 1 && m_pos[i] + 2 <= 517) np[i] = m_pos[i] + 2;
      end
    end
    for (int i = 0; i < 2; i++) begin
      m_age[i] = (ns[i] != m_state[i]) ? 0 : m_age[i] + 1;
      m_state[i] = ns[i];
      m_pos[i] = np[i];
      if (landed[i] && m_health[i] > 0) m_health[i]--;
    end
    if (m_health[0] == 0 || m_health[1] == 0) begin
      m_match = 2;
      if (m_health[0] == 0 && m_health[1] == 0) m_winner = 0;
      else m_winner = (m_health[0] == 0) ? 2 : 1;
    end
  endfunction

  // Model steps with the DUT and is compared one cycle later
  always @(posedge clk) begin
    if (rst) begin
      reset_model(0);
      pending = 1'b0;
    end else begin
      if (pending) begin
        check("p1_state", int'(p1_state), m_state[0]);
        check("p2_state", int'(p2_state), m_state[1]);
        check("p1_posx", int'(p1_posx), m_pos[0]);
        check("p2_posx", int'(p2_posx), m_pos[1]);
        check("p1_health", int'(p1_health), m_health[0]);
        check("p2_health", int'(p2_health), m_health[1]);
        check("match_state", int'(match_state), m_match);
        check("winner", int'(winner), m_winner);
      end
      pending = 1'b0;
      if (start && m_match != 1) begin
        reset_model(1);
        pending = 1'b1;
      end else if (frame_tick) begin
        step_model({p2_left, p1_left}, {p2_right, p1_right}, {p2_attack, p1_attack});
        pending = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= 4000) begin
      $display("Timeout, the run did not finish within 4000 cycles");
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic frame(input bit l1, r1, a1, l2, r2, a2);
    @(posedge clk);
    #1;
    {p1_left, p1_right, p1_attack} = {l1, r1, a1};
    {p2_left, p2_right, p2_attack} = {l2, r2, a2};
    frame_tick = 1'b1;
    @(posedge clk);
    #1 frame_tick = 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic idle_frames(input int n);
    repeat (n) frame(0, 0, 0, 0, 0, 0);
  endtask

  task automatic reset_dut();
    @(posedge clk);
    #1 rst = 1'b1;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
  endtask

  task automatic start_round();
    @(posedge clk);
    #1 start = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
    repeat (2) @(posedge clk);
  endtask

  // Both walk in to a gap of 57 within basic range
  task automatic close_in();
    repeat (45) frame(0, 1, 0, 1, 0, 0);
    idle_frames(1);
  endtask

  initial begin
    int unsigned rnd;
    int run;
    {rst, frame_tick, start} = 3'b100;
    {p1_left, p1_right, p1_attack, p2_left, p2_right, p2_attack} = 6'b0;
    void'($urandom(32'hd8d7_48d9));
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    @(posedge clk);
    check("match_state", int'(match_state), 0);
    check("p1_state", int'(p1_state), 0);
    check("p2_state", int'(p2_state), 0);
    check("p1_posx", int'(p1_posx), 100);
    check("p2_posx", int'(p2_posx), 427);
    check("p1_health", int'(p1_health), 2);
    check("p2_health", int'(p2_health), 2);
    check("winner", int'(winner), 0);
    $display("test 1 reset values done, errors %0d", errors);

    start_round();
    // Sweep out to both walls and back in to the minimum gap
    repeat (50) frame(1, 0, 0, 0, 1, 0);
    repeat (90) frame(0, 1, 0, 1, 0, 0);
    for (int k = 0; k < 12; k++) begin
      rnd = $urandom;
      run = 1 + int'(rnd[7:4]) % 8;
      repeat (run) frame(rnd[0], rnd[1], 0, rnd[2], rnd[3], 0);
    end
    $display("test 2 random walk done, errors %0d", errors);

    reset_dut();
    start_round();
    close_in();
    frame(0, 0, 1, 0, 0, 0);
    idle_frames(5);
    check("p1_state", int'(p1_state), 4);
    idle_frames(1);
    check("p2_state", int'(p2_state), 9);
    idle_frames(30);
    check("p2_health", int'(p2_health), 1);
    $display("test 3 basic hit done, errors %0d", errors);

    frame(0, 1, 0, 0, 0, 0);
    frame(0, 1, 1, 0, 0, 0);
    repeat (5) frame(0, 0, 0, 0, 1, 0);
    check("p2_state", int'(p2_state), 10);
    idle_frames(20);
    check("p2_health", int'(p2_health), 1);
    $display("test 4 blocked directional done, errors %0d", errors);

    reset_dut();
    start_round();
    frame(0, 0, 1, 0, 0, 0);
    idle_frames(25);
    check("p2_state", int'(p2_state), 0);
    check("p2_health", int'(p2_health), 2);
    $display("test 5 out of range done, errors %0d", errors);

    close_in();
    repeat (2) begin
      frame(0, 0, 1, 0, 0, 0);
      idle_frames(30);
    end
    check("match_state", int'(match_state), 2);
    check("winner", int'(winner), 1);
    start_round();
    check("p2_health", int'(p2_health), 2);
    check("p1_posx", int'(p1_posx), 100);
    check("p2_posx", int'(p2_posx), 427);
    $display("test 6 knockout and restart done, errors %0d", errors);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: fight_core.f
verilog/fight_pkg.sv
verilog/fighter_if.sv
verilog/fighter.sv
verilog/hit_judge.sv
verilog/match_ctrl.sv
verilog/fight_core.sv
verif/fight_core_chk.sv
verif/fight_core_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wall \
		-f fight_core.f --top-module fight_core_tb --Mdir obj_dir -o fight_sim

run: compile
	./obj_dir/fight_sim | tee run.log
	grep -q "^NO ERRORS$$" run.log

clean:
	rm -rf obj_dir run.log
